/* Makefile */
VERILATOR  ?= verilator
TOP        := tbPortalTop
FILELIST   := files.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
+incdir+rtl
rtl/portalPkg.sv
rtl/portalBeatIf.sv
rtl/syncFifo.sv
rtl/burstSequencer.sv
rtl/portalRegisterFile.sv
rtl/portalTop.sv
tb/portalTop_asserts.sv
tb/tbPortalTop.sv

/* rtl/burstSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "portal_config.svh"

module burstSequencer (
  input  logic                      CLK,
  input  logic                      RST_N,
  input  logic                      addrValid,
  output logic                      addrReady,
  input  logic [`PORTAL_ADDR_W-1:0] addr,
  input  logic [`PORTAL_ID_W-1:0]   id,
  input  logic [`PORTAL_LEN_W-1:0]  len,
  portalBeatIf.seq                  beats
);

  localparam int OFS_W = `PORTAL_OFS_W;
  localparam int CNT_W = `PORTAL_LEN_W + 1;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_BURST
  } seqState_e;

  seqState_e              state;
  logic [CNT_W-1:0]       beatsLeft;
  logic [OFS_W-1:0]       offset;
  logic [`PORTAL_ID_W-1:0] burstId;
  portalPkg::portalSel_e  portal;
  portalPkg::space_e      space;
  logic                   accept;
  logic                   advance;
  logic                   lastBeat;

  assign addrReady = state == SEQ_IDLE;  // one burst in flight
  assign accept    = addrValid && addrReady;
  assign advance   = beats.valid && beats.ready;
  assign lastBeat  = beatsLeft == CNT_W'(1);

  assign beats.valid = state == SEQ_BURST;
  assign beats.beat  = '{
    offset: offset,
    id:     burstId,
    last:   lastBeat,
    portal: portal,
    space:  space
  };

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state     <= SEQ_IDLE;
      beatsLeft <= '0;
    end else if (accept) begin
      state     <= SEQ_BURST;
      beatsLeft <= {1'b0, len} + CNT_W'(1);
    end else if (advance) begin
      if (lastBeat) state <= SEQ_IDLE;  // ready again next cycle
      beatsLeft <= beatsLeft - CNT_W'(1);
    end
  end

  // burst fields decoded once per burst
  always_ff @(posedge CLK) begin
    if (accept) begin
      offset  <= addr[OFS_W-1:0];
      burstId <= id;
      portal  <= portalPkg::portalSel_e'(addr[`PORTAL_ADDR_W-1]);
      space   <= (addr[`PORTAL_ADDR_W-2:OFS_W] == '0) ? portalPkg::SPACE_CTRL
                                                       : portalPkg::SPACE_DATA;
    end else if (advance) begin
      offset <= offset + OFS_W'(4);  // wraps inside the page
    end
  end

endmodule

`default_nettype wire

/* rtl/portalBeatIf.sv */
`timescale 1ns/1ps
`default_nettype none

// one decoded word access from sequencer to register file
interface portalBeatIf;

  logic             valid;
  logic             ready;
  portalPkg::beat_t beat;

  modport seq (
    output valid,
    output beat,
    input  ready
  );

  modport regs (
    input  valid,
    input  beat,
    output ready
  );

endinterface

`default_nettype wire

/* rtl/portalPkg.sv */
`default_nettype none

`include "portal_config.svh"

package portalPkg;

  // address bit 12
  typedef enum logic {
    PORTAL_IND = 1'b0,
    PORTAL_REQ = 1'b1
  } portalSel_e;

  // control page when address bits 11..5 are zero
  typedef enum logic {
    SPACE_CTRL = 1'b0,
    SPACE_DATA = 1'b1
  } space_e;

  typedef enum logic [4:0] {
    CTRL_STATUS   = 5'h00,
    CTRL_INTEN    = 5'h04,
    CTRL_VERSION  = 5'h08,
    CTRL_COUNT    = 5'h0C,
    CTRL_PORTALID = 5'h10,
    CTRL_NPORTALS = 5'h14,
    CTRL_RSVD0    = 5'h18,
    CTRL_RSVD1    = 5'h1C
  } ctrlReg_e;

  typedef struct packed {
    logic [`PORTAL_DATA_W-1:0] data;
    logic [`PORTAL_ID_W-1:0]   id;
    logic                      last;
  } rdResp_t;

  typedef struct packed {
    logic [`PORTAL_OFS_W-1:0] offset;
    logic [`PORTAL_ID_W-1:0]  id;
    logic                     last;
    portalSel_e               portal;
    space_e                   space;
  } beat_t;

endpackage

`default_nettype wire

/* rtl/portalRegisterFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "portal_config.svh"

module portalRegisterFile (
  input  logic                       CLK,
  input  logic                       RST_N,
  portalBeatIf.regs                  readBeats,
  portalBeatIf.regs                  writeBeats,
  input  logic [`PORTAL_DATA_W-1:0]  wData,
  input  logic                       wNotEmpty,
  output logic                       wPop,
  output portalPkg::rdResp_t         rResp,
  output logic                       rPush,
  input  logic                       rNotFull,
  output logic                       bPush,
  output logic [`PORTAL_ID_W-1:0]    bId,
  input  logic                       bNotFull,
  output logic                       reqPush,
  output logic [`PORTAL_DATA_W-1:0]  reqData,
  input  logic [`PORTAL_QCNT_W-1:0]  reqCount,
  input  logic                       reqNotFull,
  output logic                       indPop,
  input  logic [`PORTAL_DATA_W-1:0]  indData,
  input  logic [`PORTAL_QCNT_W-1:0]  indCount,
  input  logic                       indNotEmpty,
  output logic                       interrupt
);

  portalPkg::beat_t          rb;
  portalPkg::beat_t          wb;
  logic                      indEnable;
  logic                      reqEnable;
  logic                      rdInd;
  logic                      indDataPop;
  logic                      readFire;
  logic                      reqDataWrite;
  logic                      writeFire;
  logic [`PORTAL_DATA_W-1:0] ctrlValue;
  logic [`PORTAL_DATA_W-1:0] dataValue;

  assign rb = readBeats.beat;
  assign wb = writeBeats.beat;

  assign interrupt = indNotEmpty && indEnable;  // request portal has no source

  // read side
  assign rdInd      = rb.portal == portalPkg::PORTAL_IND;
  assign indDataPop = rdInd && rb.space == portalPkg::SPACE_DATA && rb.offset == '0;
  assign readBeats.ready = rNotFull && (!indDataPop || indNotEmpty);
  assign readFire   = readBeats.valid && readBeats.ready;
  assign rPush      = readFire;
  assign indPop     = readFire && indDataPop;

  always_comb begin
    ctrlValue = '0;
    case (portalPkg::ctrlReg_e'(rb.offset))
      portalPkg::CTRL_STATUS:   ctrlValue[0] = rdInd && indNotEmpty;
      portalPkg::CTRL_INTEN:    ctrlValue[0] = rdInd ? indEnable : reqEnable;
      portalPkg::CTRL_VERSION:  ctrlValue = `PORTAL_DATA_W'(`PORTAL_VERSION);
      portalPkg::CTRL_COUNT:    ctrlValue = rdInd ? `PORTAL_DATA_W'(indCount)
                                                  : `PORTAL_DATA_W'(reqCount);
      portalPkg::CTRL_PORTALID: ctrlValue = rdInd ? `PORTAL_DATA_W'(`PORTAL_IND_ID)
                                                  : `PORTAL_DATA_W'(`PORTAL_REQ_ID);
      portalPkg::CTRL_NPORTALS: ctrlValue = `PORTAL_DATA_W'(`PORTAL_COUNT);
      portalPkg::CTRL_RSVD0,
      portalPkg::CTRL_RSVD1:    ctrlValue = '0;
      default:                  ctrlValue = '0;  // unaligned offsets
    endcase
  end

  always_comb begin
    dataValue = '0;
    if (rdInd) begin
      if (rb.offset == `PORTAL_OFS_W'(0)) dataValue = indData;
      else if (rb.offset == `PORTAL_OFS_W'(4)) dataValue[0] = indNotEmpty;
    end else if (rb.offset == `PORTAL_OFS_W'(4)) begin
      dataValue[0] = reqNotFull;
    end
  end

  assign rResp = '{
    data: (rb.space == portalPkg::SPACE_CTRL) ? ctrlValue : dataValue,
    id:   rb.id,
    last: rb.last
  };

  // write side
  assign reqDataWrite = wb.portal == portalPkg::PORTAL_REQ && wb.space == portalPkg::SPACE_DATA;
  assign writeBeats.ready = wNotEmpty && (!reqDataWrite || reqNotFull) && (!wb.last || bNotFull);
  assign writeFire = writeBeats.valid && writeBeats.ready;
  assign wPop      = writeFire;
  assign reqPush   = writeFire && reqDataWrite;
  assign reqData   = wData;
  assign bPush     = writeFire && wb.last;  // one response per burst
  assign bId       = wb.id;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      indEnable <= 1'b0;
      reqEnable <= 1'b0;
    end else if (writeFire && wb.space == portalPkg::SPACE_CTRL &&
                 portalPkg::ctrlReg_e'(wb.offset) == portalPkg::CTRL_INTEN) begin
      if (wb.portal == portalPkg::PORTAL_IND) indEnable <= wData[0];
      else reqEnable <= wData[0];
    end
  end

endmodule

`default_nettype wire

/* rtl/portalTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "portal_config.svh"

module portalTop (
  input  logic                      CLK,
  input  logic                      RST_N,
  input  logic [`PORTAL_ADDR_W-1:0] arAddr,
  input  logic [`PORTAL_ID_W-1:0]   arId,
  input  logic [`PORTAL_LEN_W-1:0]  arLen,
  input  logic                      arValid,
  output logic                      arReady,
  output logic [`PORTAL_DATA_W-1:0] rData,
  output logic [`PORTAL_ID_W-1:0]   rId,
  output logic                      rLast,
  output logic                      rValid,
  input  logic                      rReady,
  input  logic [`PORTAL_ADDR_W-1:0] awAddr,
  input  logic [`PORTAL_ID_W-1:0]   awId,
  input  logic [`PORTAL_LEN_W-1:0]  awLen,
  input  logic                      awValid,
  output logic                      awReady,
  input  logic [`PORTAL_DATA_W-1:0] wData,
  input  logic                      wValid,
  output logic                      wReady,
  output logic [`PORTAL_ID_W-1:0]   bId,
  output logic                      bValid,
  input  logic                      bReady,
  output logic [`PORTAL_DATA_W-1:0] reqData,
  output logic                      reqValid,
  input  logic                      reqReady,
  input  logic [`PORTAL_DATA_W-1:0] indData,
  input  logic                      indValid,
  output logic                      indReady,
  output logic                      interrupt
);

  localparam int RESP_DEPTH = 2;  // R, W and B skid queues

  portalPkg::rdResp_t        rResp;
  logic                      rPush;
  logic                      rNotFull;
  logic [`PORTAL_DATA_W-1:0] wHead;
  logic                      wNotEmpty;
  logic                      wPop;
  logic                      bPush;
  logic [`PORTAL_ID_W-1:0]   bPushId;
  logic                      bNotFull;
  logic                      reqPush;
  logic [`PORTAL_DATA_W-1:0] reqWord;
  logic [`PORTAL_QCNT_W-1:0] reqCount;
  logic                      reqNotFull;
  logic                      indPop;
  logic [`PORTAL_DATA_W-1:0] indHead;
  logic [`PORTAL_QCNT_W-1:0] indCount;
  logic                      indNotEmpty;

  portalBeatIf readBeatsIf ();
  portalBeatIf writeBeatsIf ();

  burstSequencer readSeq (
    .CLK(CLK), .RST_N(RST_N),
    .addrValid(arValid), .addrReady(arReady),
    .addr(arAddr), .id(arId), .len(arLen),
    .beats(readBeatsIf.seq)
  );

  burstSequencer writeSeq (
    .CLK(CLK), .RST_N(RST_N),
    .addrValid(awValid), .addrReady(awReady),
    .addr(awAddr), .id(awId), .len(awLen),
    .beats(writeBeatsIf.seq)
  );

  portalRegisterFile regs (
    .CLK(CLK), .RST_N(RST_N),
    .readBeats(readBeatsIf.regs), .writeBeats(writeBeatsIf.regs),
    .wData(wHead), .wNotEmpty(wNotEmpty), .wPop(wPop),
    .rResp(rResp), .rPush(rPush), .rNotFull(rNotFull),
    .bPush(bPush), .bId(bPushId), .bNotFull(bNotFull),
    .reqPush(reqPush), .reqData(reqWord), .reqCount(reqCount), .reqNotFull(reqNotFull),
    .indPop(indPop), .indData(indHead), .indCount(indCount), .indNotEmpty(indNotEmpty),
    .interrupt(interrupt)
  );

  syncFifo #(.WIDTH($bits(portalPkg::rdResp_t)), .DEPTH(RESP_DEPTH)) rQueue (
    .CLK(CLK), .RST_N(RST_N),
    .push(rPush), .pushData(rResp),
    .pop(rValid && rReady), .popData({rData, rId, rLast}),
    .notEmpty(rValid), .notFull(rNotFull), .count()
  );

  syncFifo #(.WIDTH(`PORTAL_DATA_W), .DEPTH(RESP_DEPTH)) wQueue (
    .CLK(CLK), .RST_N(RST_N),
    .push(wValid && wReady), .pushData(wData),
    .pop(wPop), .popData(wHead),
    .notEmpty(wNotEmpty), .notFull(wReady), .count()
  );

  syncFifo #(.WIDTH(`PORTAL_ID_W), .DEPTH(RESP_DEPTH)) bQueue (
    .CLK(CLK), .RST_N(RST_N),
    .push(bPush), .pushData(bPushId),
    .pop(bValid && bReady), .popData(bId),
    .notEmpty(bValid), .notFull(bNotFull), .count()
  );

  // request portal out to the user stream
  syncFifo #(.WIDTH(`PORTAL_DATA_W), .DEPTH(`PORTAL_QDEPTH)) reqQueue (
    .CLK(CLK), .RST_N(RST_N),
    .push(reqPush), .pushData(reqWord),
    .pop(reqValid && reqReady), .popData(reqData),
    .notEmpty(reqValid), .notFull(reqNotFull), .count(reqCount)
  );

  syncFifo #(.WIDTH(`PORTAL_DATA_W), .DEPTH(`PORTAL_QDEPTH)) indQueue (
    .CLK(CLK), .RST_N(RST_N),
    .push(indValid && indReady), .pushData(indData),
    .pop(indPop), .popData(indHead),
    .notEmpty(indNotEmpty), .notFull(indReady), .count(indCount)
  );

endmodule

`default_nettype wire

/* rtl/portal_config.svh */
`ifndef PORTAL_CONFIG_SVH
`define PORTAL_CONFIG_SVH

// bus geometry
`define PORTAL_ADDR_W 13
`define PORTAL_DATA_W 32
`define PORTAL_ID_W 6
`define PORTAL_LEN_W 4   // beats = len + 1
`define PORTAL_OFS_W 5   // word offset within a page

// indication and request queues
`define PORTAL_QDEPTH 4
`define PORTAL_QCNT_W ($clog2(`PORTAL_QDEPTH + 1))

// fixed control page values
`define PORTAL_VERSION 1
`define PORTAL_COUNT 2
`define PORTAL_IND_ID 5
`define PORTAL_REQ_ID 6

`endif

/* rtl/syncFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 2
) (
  input  logic                       CLK,
  input  logic                       RST_N,
  input  logic                       push,
  input  logic [WIDTH-1:0]           pushData,
  input  logic                       pop,
  output logic [WIDTH-1:0]           popData,
  output logic                       notEmpty,
  output logic                       notFull,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] wrPtr;
  logic             doPush;
  logic             doPop;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign doPush   = push && notFull;  // guarded on both sides
  assign doPop    = pop && notEmpty;
  assign notEmpty = count != '0;
  assign notFull  = count != CNT_W'(DEPTH);
  assign popData  = mem[rdPtr];  // head of queue

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= nextPtr(wrPtr);
      if (doPop) rdPtr <= nextPtr(rdPtr);
      if (doPush && !doPop) count <= count + CNT_W'(1);
      else if (doPop && !doPush) count <= count - CNT_W'(1);
    end
  end

  always_ff @(posedge CLK) begin
    if (doPush) mem[wrPtr] <= pushData;
  end

endmodule

`default_nettype wire

/* tb/portalTop_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "portal_config.svh"

module portalTopAsserts (
  input logic                      CLK,
  input logic                      RST_N,
  input logic                      rValid,
  input logic                      rReady,
  input logic [`PORTAL_DATA_W-1:0] rData,
  input logic [`PORTAL_ID_W-1:0]   rId,
  input logic                      rLast,
  input logic                      bValid,
  input logic                      bReady,
  input logic [`PORTAL_ID_W-1:0]   bId,
  input logic                      reqValid,
  input logic                      reqReady,
  input logic [`PORTAL_DATA_W-1:0] reqData,
  input logic                      interrupt,
  input logic                      indEnable
);

  rHeld: assert property (@(posedge CLK) disable iff (!RST_N)
    rValid && !rReady |=> rValid && $stable({rData, rId, rLast}))
    else $error("R response dropped or changed before rReady");

  bHeld: assert property (@(posedge CLK) disable iff (!RST_N)
    bValid && !bReady |=> bValid && $stable(bId))
    else $error("B response dropped or changed before bReady");

  reqHeld: assert property (@(posedge CLK) disable iff (!RST_N)
    reqValid && !reqReady |=> reqValid && $stable(reqData))
    else $error("request word dropped or changed before reqReady");

  // only the indication portal can raise the line
  intGated: assert property (@(posedge CLK) disable iff (!RST_N)
    !indEnable |-> !interrupt)
    else $error("interrupt high with the indication enable clear");

endmodule

bind portalTop portalTopAsserts asserts (
  .CLK(CLK), .RST_N(RST_N),
  .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
  .bValid(bValid), .bReady(bReady), .bId(bId),
  .reqValid(reqValid), .reqReady(reqReady), .reqData(reqData),
  .interrupt(interrupt), .indEnable(regs.indEnable)
);

`default_nettype wire

/* tb/tbPortalTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "portal_config.svh"

module tbPortalTop;

  localparam int DW = `PORTAL_DATA_W;
  localparam int TIMEOUT_CYCLES = 4000;  // directed run needs a few hundred cycles

  logic                      CLK;
  logic                      RST_N;
  logic [`PORTAL_ADDR_W-1:0] arAddr;
  logic [`PORTAL_ID_W-1:0]   arId;
  logic [`PORTAL_LEN_W-1:0]  arLen;
  logic                      arValid;
  logic                      arReady;
  logic [DW-1:0]             rData;
  logic [`PORTAL_ID_W-1:0]   rId;
  logic                      rLast;
  logic                      rValid;
  logic                      rReady;
  logic [`PORTAL_ADDR_W-1:0] awAddr;
  logic [`PORTAL_ID_W-1:0]   awId;
  logic [`PORTAL_LEN_W-1:0]  awLen;
  logic                      awValid;
  logic                      awReady;
  logic [DW-1:0]             wData;
  logic                      wValid;
  logic                      wReady;
  logic [`PORTAL_ID_W-1:0]   bId;
  logic                      bValid;
  logic                      bReady;
  logic [DW-1:0]             reqData;
  logic                      reqValid;
  logic                      reqReady;
  logic [DW-1:0]             indData;
  logic                      indValid;
  logic                      indReady;
  logic                      interrupt;

  int            valueErrors = 0;
  int            otherErrors = 0;
  int            cycles = 0;
  logic [15:0]   lfsr;
  logic [DW-1:0] rdWords[$];
  logic [DW-1:0] wrWords[$];
  logic [DW-1:0] reqSeen[$];

  portalTop UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // request stream monitor
  always @(posedge CLK) begin
    if (RST_N && reqValid && reqReady) reqSeen.push_back(reqData);
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, run still busy after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Fibonacci taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [DW-1:0] nextWord();
    logic [DW-1:0] word;
    word = '0;
    for (int i = 0; i < DW; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      word = {word[DW-2:0], lfsr[0]};
    end
    return word;
  endfunction

  task automatic tick();
    @(posedge CLK);
    #1;
  endtask

  task automatic valueMismatch(input string name, input logic [DW-1:0] expected,
                               input logic [DW-1:0] actual);
    valueErrors++;
    $display("FAILED %s expected %h actual %h", name, expected, actual);
  endtask

  task automatic protocolError(input string what);
    otherErrors++;
    $display("error at cycle %0d, %s", cycles, what);
  endtask

  task automatic busRead(input logic [`PORTAL_ADDR_W-1:0] addr, input logic [`PORTAL_ID_W-1:0] id,
                         input logic [`PORTAL_LEN_W-1:0] len, input int holdCycles);
    int beat;
    rdWords.delete();
    arAddr = addr;
    arId = id;
    arLen = len;
    arValid = 1'b1;
    while (!arReady) tick();
    tick();
    arValid = 1'b0;
    repeat (holdCycles) tick();  // R channel stalled meanwhile
    if (holdCycles > 0 && arReady) protocolError("arReady high while the R queue was stalled");
    rReady = 1'b1;
    beat = 0;
    while (beat <= int'(len)) begin
      if (rValid) begin
        rdWords.push_back(rData);
        if (rId !== id) valueMismatch("rId", DW'(id), DW'(rId));
        if (rLast !== (beat == int'(len)))
          valueMismatch("rLast", DW'(beat == int'(len)), DW'(rLast));
        beat++;
      end
      tick();
    end
    rReady = 1'b0;
  endtask

  task automatic busWrite(input logic [`PORTAL_ADDR_W-1:0] addr,
                          input logic [`PORTAL_ID_W-1:0] id);
    awAddr = addr;
    awId = id;
    awLen = `PORTAL_LEN_W'(wrWords.size() - 1);
    awValid = 1'b1;
    while (!awReady) tick();
    tick();
    awValid = 1'b0;
    foreach (wrWords[i]) begin
      wData = wrWords[i];
      wValid = 1'b1;
      while (!wReady) tick();
      tick();
    end
    wValid = 1'b0;
    while (!awReady) tick();  // every beat of the burst consumed
    if (!bValid) protocolError("no B response after the write burst");
    else if (bId !== id) valueMismatch("bId", DW'(id), DW'(bId));
    bReady = 1'b1;
    tick();
    bReady = 1'b0;
    if (bValid) protocolError("write burst gave more than one B response");
  endtask

  task automatic writeWord(input logic [`PORTAL_ADDR_W-1:0] addr, input logic [DW-1:0] word);
    wrWords.delete();
    wrWords.push_back(word);
    busWrite(addr, 6'h05);
  endtask

  task automatic readExpect(input logic [`PORTAL_ADDR_W-1:0] addr,
                            input logic [DW-1:0] expected);
    busRead(addr, 6'h07, '0, 0);
    if (rdWords[0] !== expected) valueMismatch($sformatf("rData@%h", addr), expected, rdWords[0]);
  endtask

  task automatic pushIndication(input logic [DW-1:0] word);
    indData = word;
    indValid = 1'b1;
    while (!indReady) tick();
    tick();
    indValid = 1'b0;
  endtask

  // status, enable, version, count, id, portals, two reserved
  task automatic controlPage(input logic portal, input logic [`PORTAL_ID_W-1:0] id,
                             input int holdCycles);
    logic [DW-1:0] expected [8];
    expected = '{32'd0, 32'd0, 32'd1, 32'd0, 32'd5, 32'd2, 32'd0, 32'd0};
    if (portal) expected[4] = 32'd6;
    busRead({portal, 12'h000}, id, 4'd7, holdCycles);
    foreach (expected[i]) begin
      if (rdWords[i] !== expected[i])
        valueMismatch($sformatf("rData[%0d]", i), expected[i], rdWords[i]);
    end
  endtask

  task automatic interruptEnable();
    logic [DW-1:0] word;
    word = nextWord();
    writeWord(13'h0004, 32'd1);
    if (interrupt !== 1'b0) valueMismatch("interrupt", 32'd0, DW'(interrupt));
    pushIndication(word);
    if (interrupt !== 1'b1) valueMismatch("interrupt", 32'd1, DW'(interrupt));
    busRead(13'h0000, 6'h12, 4'd3, 0);  // status, enable, version, count all read 1
    foreach (rdWords[i]) begin
      if (rdWords[i] !== 32'd1) valueMismatch($sformatf("rData[%0d]", i), 32'd1, rdWords[i]);
    end
    writeWord(13'h0004, 32'd0);
    if (interrupt !== 1'b0) valueMismatch("interrupt", 32'd0, DW'(interrupt));
    readExpect(13'h0020, word);  // drain for the next test
  endtask

  task automatic indicationReads();
    logic [DW-1:0] words [3];
    writeWord(13'h0004, 32'd1);
    foreach (words[i]) begin
      words[i] = nextWord();
      pushIndication(words[i]);
    end
    if (interrupt !== 1'b1) valueMismatch("interrupt", 32'd1, DW'(interrupt));
    readExpect(13'h0024, 32'd1);
    foreach (words[i]) readExpect(13'h0020, words[i]);
    readExpect(13'h0024, 32'd0);
    if (interrupt !== 1'b0) valueMismatch("interrupt", 32'd0, DW'(interrupt));
    writeWord(13'h0004, 32'd0);
  endtask

  task automatic requestBurst(input int words, input logic [`PORTAL_ID_W-1:0] id);
    reqSeen.delete();
    wrWords.delete();
    repeat (words) wrWords.push_back(nextWord());
    busWrite(13'h1020, id);
    if (!reqReady) begin
      readExpect(13'h1024, 32'd0);  // queue full
      readExpect(13'h100C, DW'(words));
      reqReady = 1'b1;
    end
    while (reqSeen.size() < words) tick();
    foreach (wrWords[i]) begin
      if (reqSeen[i] !== wrWords[i])
        valueMismatch($sformatf("reqData[%0d]", i), wrWords[i], reqSeen[i]);
    end
    if (reqValid) protocolError("request stream delivered more words than written");
  endtask

  task automatic backPressure();
    reqReady = 1'b0;
    requestBurst(`PORTAL_QDEPTH, 6'h33);
    controlPage(1'b0, 6'h3C, 12);
  endtask

  initial begin
    lfsr = 16'd8;
    RST_N = 1'b0;
    arAddr = '0;
    arId = '0;
    arLen = '0;
    arValid = 1'b0;
    rReady = 1'b0;
    awAddr = '0;
    awId = '0;
    awLen = '0;
    awValid = 1'b0;
    wData = '0;
    wValid = 1'b0;
    bReady = 1'b0;
    reqReady = 1'b0;
    indData = '0;
    indValid = 1'b0;
    repeat (8) @(posedge CLK);
    #1;
    RST_N = 1'b1;
    if (rValid || bValid || reqValid || interrupt) protocolError("outputs not idle after reset");
    controlPage(1'b0, 6'h11, 0);
    controlPage(1'b1, 6'h12, 0);
    interruptEnable();
    indicationReads();
    reqReady = 1'b1;
    requestBurst(4, 6'h2A);
    backPressure();
    $display("value errors %0d, other errors %0d, cycles %0d", valueErrors, otherErrors, cycles);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
